// File: common/store_macros.svh
// Buffer geometry only; STORE_DEPTH must stay 2**STORE_ADDR_WIDTH so address math wraps by width
`ifndef STORE_MACROS_SVH
`define STORE_MACROS_SVH

////////////////////////////////////////////////////////////
// Store buffer geometry
////////////////////////////////////////////////////////////

`define STORE_ADDR_WIDTH 10     // Word address bits
`define STORE_DATA_WIDTH 32     // Stored word bits
`define STORE_DEPTH      1024   // Words in buffer

`endif

// File: common/store_pkg.sv
// Types for the strided store unit; address_t also carries strides, sums wrap modulo STORE_DEPTH
`include "store_macros.svh"

package store_pkg;

	////////////////////////////////////////////////////////////
	// Address and data words
	////////////////////////////////////////////////////////////

	// Buffer word address, also used for strides
	typedef logic [`STORE_ADDR_WIDTH-1:0] address_t;

	// Beat count 0 .. STORE_DEPTH, hence one extra bit
	typedef logic [`STORE_ADDR_WIDTH:0] length_t;

	typedef logic [`STORE_DATA_WIDTH-1:0] data_t;   // One stored word

	////////////////////////////////////////////////////////////
	// Lane index
	////////////////////////////////////////////////////////////

	typedef logic lane_no_t;                        // 0 is lane 1, 1 is lane 2

endpackage

// File: common/store_job_if.sv
// One lane's job request; base, stride and length must hold steady while req is high
`timescale 1ns/1ps

interface store_job_if
	import store_pkg::*;
;

	logic     req;          // Job pending
	address_t base_addr;    // First write address
	address_t stride;       // Address step per beat
	length_t  length;       // Beats in job
	logic     grant;        // Lane owns the store path

	// Lane side
	modport requester (
		output req,
		output base_addr,
		output stride,
		output length,
		input  grant
	);

	// Arbiter side
	modport arbiter (
		input  req,
		input  base_addr,
		input  stride,
		input  length,
		output grant
	);

endinterface

// File: store_unit/store_arbiter.sv
// Fixed priority with lane 1 winning ties; grant holds until done and one idle cycle follows
`timescale 1ns/1ps

module store_arbiter
	import store_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	store_job_if.arbiter lane1,
	store_job_if.arbiter lane2,
	input  logic         done,         // Last beat of current job
	output logic         start,        // First granted cycle
	output lane_no_t     grant_no,     // Lane that owns the job
	output address_t     job_base,
	output address_t     job_stride,
	output length_t      job_length
);

	logic grant1_q;     // Lane 1 owns the path
	logic grant2_q;     // Lane 2 owns the path
	logic release_q;    // Idle cycle after done
	logic start_q;
	logic idle;
	logic take1;
	logic take2;

	////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////

	assign idle  = ~grant1_q & ~grant2_q & ~release_q;
	assign take1 = idle & lane1.req;                 // Lane 1 has priority
	assign take2 = idle & lane2.req & ~lane1.req;    // Only when lane 1 is quiet

	always_ff @(posedge clock) begin
		if (reset) begin
			grant1_q <= 1'b0;
		end else if (done) begin
			grant1_q <= 1'b0;                        // Job finished
		end else if (take1) begin
			grant1_q <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			grant2_q <= 1'b0;
		end else if (done) begin
			grant2_q <= 1'b0;
		end else if (take2) begin
			grant2_q <= 1'b1;
		end
	end

	// Release cycle and start pulse
	always_ff @(posedge clock) begin
		if (reset) begin
			release_q <= 1'b0;
			start_q   <= 1'b0;
		end else begin
			release_q <= done;                       // Blocks re-arbitration for one cycle
			start_q   <= take1 | take2;              // Rises with the new grant
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	assign lane1.grant = grant1_q;
	assign lane2.grant = grant2_q;
	assign start       = start_q;
	assign grant_no    = lane_no_t'(grant2_q);

	// Job fields follow the granted lane, not the raw requests
	assign job_base   = grant2_q ? lane2.base_addr : lane1.base_addr;
	assign job_stride = grant2_q ? lane2.stride    : lane1.stride;
	assign job_length = grant2_q ? lane2.length    : lane1.length;

endmodule

// File: store_unit/stride_addr_gen.sv
// One write per cycle with no back-pressure; granted lane must present a word every beat
`timescale 1ns/1ps

module stride_addr_gen
	import store_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     start,        // Job granted this cycle
	input  lane_no_t grant_no,
	input  address_t job_base,
	input  address_t job_stride,
	input  length_t  job_length,
	input  data_t    data1,        // Lane 1 current word
	input  data_t    data2,        // Lane 2 current word
	output logic     wr_en,
	output address_t wr_addr,
	output data_t    wr_data,
	output logic     ack1,         // Lane 1 word taken
	output logic     ack2,         // Lane 2 word taken
	output logic     done          // Last beat or empty job
);

	logic     busy_q;       // Beats in flight
	logic     empty_q;      // Zero-length job seen
	lane_no_t lane_q;       // Lane of current job
	address_t addr_q;       // Running write address
	address_t stride_q;
	length_t  remain_q;     // Beats left, including this one
	logic     last_beat;

	////////////////////////////////////////////////////////////
	// Control state
	////////////////////////////////////////////////////////////

	assign last_beat = busy_q & (remain_q == length_t'(1));

	always_ff @(posedge clock) begin
		if (reset) begin
			busy_q  <= 1'b0;
			empty_q <= 1'b0;
		end else begin
			empty_q <= start & (job_length == '0);   // Done next cycle, no writes
			if (start) begin
				busy_q <= (job_length != '0);
			end else if (last_beat) begin
				busy_q <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Address walk
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (start) begin
			lane_q   <= grant_no;
			addr_q   <= job_base;                    // Beat 0 address
			stride_q <= job_stride;
			remain_q <= job_length;
		end else if (busy_q) begin
			addr_q   <= addr_q + stride_q;           // Wraps at buffer depth
			remain_q <= remain_q - length_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Write port and handshakes
	////////////////////////////////////////////////////////////

	assign wr_en   = busy_q;
	assign wr_addr = addr_q;
	assign wr_data = lane_q ? data2 : data1;         // Granted lane's word

	assign ack1 = busy_q & ~lane_q;
	assign ack2 = busy_q &  lane_q;
	assign done = last_beat | empty_q;

endmodule

// File: source/store_buffer_ram.sv
// Contents are undefined after power-up; read data arrives one cycle after the address
`timescale 1ns/1ps
`include "store_macros.svh"

module store_buffer_ram
	import store_pkg::*;
(
	input  logic     clock,
	input  logic     wr_en,
	input  address_t wr_addr,
	input  data_t    wr_data,
	input  address_t rd_addr,
	output data_t    rd_data
);

	data_t mem [`STORE_DEPTH];     // Word storage
	data_t rd_data_q;              // Registered read word

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Independent of the write port; same-address read returns the old word
	always_ff @(posedge clock) begin
		rd_data_q <= mem[rd_addr];
	end

	assign rd_data = rd_data_q;

endmodule

// File: source/store_unit_top.sv
// Two lanes share one store path; a lane drops req the cycle after done and waits otherwise
`timescale 1ns/1ps

module store_unit_top
	import store_pkg::*;
(
	input  logic     clock,
	input  logic     reset,

	// Lane 1
	input  logic     req1,
	input  address_t base_addr1,
	input  address_t stride1,
	input  length_t  length1,
	input  data_t    data1,
	output logic     grant1,
	output logic     ack1,

	// Lane 2
	input  logic     req2,
	input  address_t base_addr2,
	input  address_t stride2,
	input  length_t  length2,
	input  data_t    data2,
	output logic     grant2,
	output logic     ack2,

	output logic     done,          // Job finished
	input  address_t read_addr,     // Observation port
	output data_t    read_data
);

	store_job_if lane1_if ();
	store_job_if lane2_if ();

	logic     start;
	lane_no_t grant_no;
	address_t job_base;
	address_t job_stride;
	length_t  job_length;
	logic     wr_en;
	address_t wr_addr;
	data_t    wr_data;

	////////////////////////////////////////////////////////////
	// Lane ports to job interfaces
	////////////////////////////////////////////////////////////

	assign lane1_if.req       = req1;
	assign lane1_if.base_addr = base_addr1;
	assign lane1_if.stride    = stride1;
	assign lane1_if.length    = length1;
	assign grant1             = lane1_if.grant;

	assign lane2_if.req       = req2;
	assign lane2_if.base_addr = base_addr2;
	assign lane2_if.stride    = stride2;
	assign lane2_if.length    = length2;
	assign grant2             = lane2_if.grant;

	////////////////////////////////////////////////////////////
	// Store path
	////////////////////////////////////////////////////////////

	store_arbiter i_store_arbiter (
		.clock      (clock),
		.reset      (reset),
		.lane1      (lane1_if.arbiter),
		.lane2      (lane2_if.arbiter),
		.done       (done),
		.start      (start),
		.grant_no   (grant_no),
		.job_base   (job_base),
		.job_stride (job_stride),
		.job_length (job_length)
	);

	stride_addr_gen i_stride_addr_gen (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.grant_no   (grant_no),
		.job_base   (job_base),
		.job_stride (job_stride),
		.job_length (job_length),
		.data1      (data1),
		.data2      (data2),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.ack1       (ack1),
		.ack2       (ack2),
		.done       (done)
	);

	store_buffer_ram i_store_buffer_ram (
		.clock   (clock),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (read_addr),
		.rd_data (read_data)
	);

endmodule

// File: tests/store_unit_tasks.svh
// Lane driver and directed tests; included inside the testbench module, uses its signals and model

////////////////////////////////////////////////////////////
// Lane port access
////////////////////////////////////////////////////////////

task automatic set_job(input lane_no_t lane, input address_t base, input address_t stride,
		input length_t len);
	if (lane == 1'b0) begin
		base_addr1 = base;
		stride1    = stride;
		length1    = len;
		req1       = 1'b1;
	end else begin
		base_addr2 = base;
		stride2    = stride;
		length2    = len;
		req2       = 1'b1;
	end
endtask

task automatic set_req(input lane_no_t lane, input logic value);
	if (lane == 1'b0) req1 = value;
	else req2 = value;
endtask

task automatic set_word(input lane_no_t lane, input data_t word);
	if (lane == 1'b0) data1 = word;
	else data2 = word;
endtask

function automatic logic lane_grant(input lane_no_t lane);
	return lane ? grant2 : grant1;
endfunction

function automatic logic lane_ack(input lane_no_t lane);
	return lane ? ack2 : ack1;
endfunction

function automatic data_t lane_word(input lane_no_t lane);
	return lane ? data2 : data1;
endfunction

////////////////////////////////////////////////////////////
// Expected behavior
////////////////////////////////////////////////////////////

// Beat i lands at base + i * stride, wrapped to the buffer
function automatic address_t expected_address(input address_t base, input address_t stride,
		input int index);
	int offset;
	offset = (int'(base) + index * int'(stride)) % `STORE_DEPTH;
	return address_t'(offset);
endfunction

// Done marks the last write, or follows start by one cycle for an empty job
function automatic length_t expected_done_delay(input length_t len);
	return (len == '0) ? length_t'(1) : len;
endfunction

task automatic record_beat(input lane_no_t lane, input address_t base, input address_t stride,
		input int index);
	address_t addr;
	addr            = expected_address(base, stride, index);
	model_mem[addr] = lane_word(lane);   // Later writes win
	model_set[addr] = 1'b1;
	set_word(lane, next_word());         // Next word after the write edge
endtask

////////////////////////////////////////////////////////////
// Lane driver
////////////////////////////////////////////////////////////

task automatic run_lane(input string test_name, input lane_no_t lane, input address_t base,
		input address_t stride, input length_t len, output int req_cycle,
		output int grant_cycle, output int done_cycle, output int acks);
	int waited;
	bit ack_prev;                        // Word presented last cycle was written

	req_cycle   = -1;
	grant_cycle = -1;
	done_cycle  = -1;
	acks        = 0;
	ack_prev    = 1'b0;
	@(posedge clock);
	#DRIVE_DELAY;
	set_job(lane, base, stride, len);
	req_cycle = cycle;

	waited = 0;
	while (grant_cycle < 0 && waited < GRANT_TIMEOUT) begin
		@(posedge clock);
		#DRIVE_DELAY;
		waited++;
		if (lane_grant(lane)) begin
			grant_cycle = cycle;
			if (grant1 && grant2) report_failure({test_name, ": both grants high together"});
			set_word(lane, next_word());     // Ready for beat 0
		end
	end
	if (grant_cycle < 0) begin
		report_timeout($sformatf("%s: lane %0d got no grant within %0d cycles", test_name,
			int'(lane) + 1, GRANT_TIMEOUT));
		set_req(lane, 1'b0);
		return;
	end

	waited = 0;
	while (done_cycle < 0 && waited < int'(len) + DONE_SLACK) begin
		@(posedge clock);
		#DRIVE_DELAY;
		waited++;
		if (ack_prev) begin
			record_beat(lane, base, stride, acks);
			acks++;
		end
		ack_prev = lane_ack(lane);
		if (lane_grant(lane_no_t'(~lane)) || lane_ack(lane_no_t'(~lane)))
			report_failure({test_name, ": the other lane was active during this job"});
		if (done && lane_grant(lane)) done_cycle = cycle;
	end
	if (done_cycle < 0) begin
		report_timeout({test_name, ": done never came for the granted job"});
		set_req(lane, 1'b0);
		return;
	end

	@(posedge clock);                    // Last word written at this edge
	#DRIVE_DELAY;
	if (ack_prev) begin
		record_beat(lane, base, stride, acks);
		acks++;
	end
	if (lane_grant(lane)) report_failure({test_name, ": grant still high after done"});
	set_req(lane, 1'b0);
endtask

////////////////////////////////////////////////////////////
// Checks shared by the tests
////////////////////////////////////////////////////////////

task automatic check_reset_state();
	if (grant1 || grant2 || ack1 || ack2 || done)
		report_failure("Outputs not all low after reset");
endtask

task automatic check_job(input string test_name, input length_t len, input int grant_cycle,
		input int done_cycle, input int acks);
	if (grant_cycle >= 0 && done_cycle >= 0) begin
		compare_length({test_name, " done delay"}, expected_done_delay(len),
			length_t'(done_cycle - grant_cycle));
		compare_length({test_name, " beats"}, len, length_t'(acks));
	end
endtask

// Read back every word the model knows, one address per two cycles
task automatic check_buffer(input string test_name);
	int addr;
	for (addr = 0; addr < `STORE_DEPTH; addr++) begin
		if (model_set[addr]) begin
			@(posedge clock);
			#DRIVE_DELAY;
			read_addr = address_t'(addr);
			@(posedge clock);
			#DRIVE_DELAY;
			compare_data($sformatf("%s addr %0d", test_name, addr), model_mem[addr], read_data);
		end
	end
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic single_lane1();
	int req_c;
	int grant_c;
	int done_c;
	int acks;
	run_lane("single_lane1", 1'b0, 10'd100, 10'd3, 11'd8, req_c, grant_c, done_c, acks);
	compare_length("single_lane1 grant delay", 11'd1, length_t'(grant_c - req_c));
	check_job("single_lane1", 11'd8, grant_c, done_c, acks);
	check_buffer("single_lane1");
endtask

task automatic single_lane2();
	int req_c;
	int grant_c;
	int done_c;
	int acks;
	run_lane("single_lane2", 1'b1, 10'd400, 10'd7, 11'd8, req_c, grant_c, done_c, acks);
	compare_length("single_lane2 grant delay", 11'd1, length_t'(grant_c - req_c));
	check_job("single_lane2", 11'd8, grant_c, done_c, acks);
	check_buffer("single_lane2");
endtask

task automatic both_request();
	int req1_c;
	int grant1_c;
	int done1_c;
	int acks1;
	int req2_c;
	int grant2_c;
	int done2_c;
	int acks2;
	fork
		run_lane("both_request lane1", 1'b0, 10'd200, 10'd1, 11'd6, req1_c, grant1_c, done1_c,
			acks1);
		run_lane("both_request lane2", 1'b1, 10'd300, 10'd2, 11'd5, req2_c, grant2_c, done2_c,
			acks2);
	join
	compare_lane("both_request first grant", 1'b0, lane_no_t'(grant2_c < grant1_c));
	compare_length("both_request lane1 grant delay", 11'd1, length_t'(grant1_c - req1_c));
	// Done cycle, release cycle, arbitration cycle, then lane 2 holds the grant
	compare_length("both_request lane2 after release", 11'd3, length_t'(grant2_c - done1_c));
	// Lane 1 grant, its six beats, then release and arbitration
	compare_length("both_request lane2 wait", 11'd10, length_t'(grant2_c - req2_c));
	check_job("both_request lane1", 11'd6, grant1_c, done1_c, acks1);
	check_job("both_request lane2", 11'd5, grant2_c, done2_c, acks2);
	check_buffer("both_request");
endtask

task automatic wrap_and_overlap();
	int req_c;
	int grant_c;
	int done_c;
	int acks;
	// 1020, 1, 6, 11, 16, 21 after wrap
	run_lane("wrap_and_overlap wrap", 1'b0, 10'd1020, 10'd5, 11'd6, req_c, grant_c, done_c, acks);
	compare_length("wrap_and_overlap wrap grant delay", 11'd1, length_t'(grant_c - req_c));
	check_job("wrap_and_overlap wrap", 11'd6, grant_c, done_c, acks);
	// Stride 0 rewrites address 6 four times
	run_lane("wrap_and_overlap same", 1'b1, 10'd6, 10'd0, 11'd4, req_c, grant_c, done_c, acks);
	compare_length("wrap_and_overlap same grant delay", 11'd1, length_t'(grant_c - req_c));
	check_job("wrap_and_overlap same", 11'd4, grant_c, done_c, acks);
	check_buffer("wrap_and_overlap");
endtask

task automatic zero_length();
	int req_c;
	int grant_c;
	int done_c;
	int acks;
	// Base sits on words from single_lane1
	run_lane("zero_length", 1'b0, 10'd100, 10'd1, 11'd0, req_c, grant_c, done_c, acks);
	compare_length("zero_length grant delay", 11'd1, length_t'(grant_c - req_c));
	check_job("zero_length", 11'd0, grant_c, done_c, acks);
	check_buffer("zero_length");
endtask

// File: tests/store_unit_tb.sv
// Directed tests for the store unit; needs simulator timing support and checks only written words
`timescale 1ns/1ps
`include "store_macros.svh"

module store_unit_tb
	import store_pkg::*;
;

	localparam real DRIVE_DELAY   = 0.5;   // Input change after rising edge
	localparam int  GRANT_TIMEOUT = 64;    // Cycles a lane may wait for grant
	localparam int  DONE_SLACK    = 16;    // Extra cycles beyond job length

	logic     clock;
	logic     reset;
	logic     req1;
	address_t base_addr1;
	address_t stride1;
	length_t  length1;
	data_t    data1;
	logic     grant1;
	logic     ack1;
	logic     req2;
	address_t base_addr2;
	address_t stride2;
	length_t  length2;
	data_t    data2;
	logic     grant2;
	logic     ack2;
	logic     done;
	address_t read_addr;
	data_t    read_data;

	int          cycle;                    // Rising edges since time zero
	int          error_count;
	int          timeout_count;
	logic [31:0] lcg_state;
	data_t       model_mem [`STORE_DEPTH]; // Expected buffer contents
	bit          model_set [`STORE_DEPTH]; // Word has been written

	store_unit_top i_store_unit_top (.*);

	always #2 clock = ~clock;              // 4 ns period

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	////////////////////////////////////////////////////////////
	// Data source and result checks
	////////////////////////////////////////////////////////////

	function automatic data_t next_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
		return data_t'(lcg_state);
	endfunction

	task automatic compare_data(input string test_name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic compare_lane(input string test_name, input lane_no_t expected,
			input lane_no_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("ERROR %s: expected lane %0d, actual lane %0d", test_name,
				int'(expected) + 1, int'(actual) + 1);
		end
	endtask

	task automatic compare_length(input string test_name, input length_t expected,
			input length_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("ERROR %s: expected %0d, actual %0d", test_name, expected, actual);
		end
	endtask

	task automatic report_failure(input string text);
		error_count++;
		$display("%s", text);
	endtask

	task automatic report_timeout(input string text);
		timeout_count++;
		$display("%s", text);
	endtask

	`include "store_unit_tasks.svh"

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int index;

		clock         = 1'b0;
		reset         = 1'b1;
		req1          = 1'b0;
		base_addr1    = '0;
		stride1       = '0;
		length1       = '0;
		data1         = '0;
		req2          = 1'b0;
		base_addr2    = '0;
		stride2       = '0;
		length2       = '0;
		data2         = '0;
		read_addr     = '0;
		error_count   = 0;
		timeout_count = 0;
		lcg_state     = 32'h8682;
		for (index = 0; index < `STORE_DEPTH; index++) begin
			model_set[index] = 1'b0;
		end

		repeat (2) @(posedge clock);   // Two reset cycles
		#DRIVE_DELAY;
		reset = 1'b0;
		check_reset_state();

		single_lane1();
		single_lane2();
		both_request();
		wrap_and_overlap();
		zero_length();

		$display("Closing: %0d errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
+incdir+tests
common/store_pkg.sv
common/store_job_if.sv
store_unit/store_arbiter.sv
store_unit/stride_addr_gen.sv
source/store_buffer_ram.sv
source/store_unit_top.sv
tests/store_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the store unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing \
	-f compile.f \
	--top-module store_unit_tb \
	-Mdir "$BUILD_DIR" \
	-o store_unit_sim

"./$BUILD_DIR/store_unit_sim" | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi

exit 0
